/* src/rv_exec_pkg.sv */
// shared definitions for the rv32i integer execute slice
// widths, alu operation codes, major opcodes and the instruction word
// rtl and testbench refer to these by scoped name, no import
package rv_exec_pkg;

	localparam int xlen       = 32; // data path width
	localparam int reg_addr_w = 5;  // register index width, 32 entries

	// alu operation codes
	// numbering follows the older alu, codes 2, 6 and 7 stay free
	localparam logic [3:0] alu_add    = 4'd0;
	localparam logic [3:0] alu_sub    = 4'd1;
	localparam logic [3:0] alu_slt    = 4'd3;  // signed compare
	localparam logic [3:0] alu_sltu   = 4'd4;  // unsigned compare
	localparam logic [3:0] alu_xor    = 4'd5;
	localparam logic [3:0] alu_or     = 4'd8;
	localparam logic [3:0] alu_and    = 4'd9;
	localparam logic [3:0] alu_pass_b = 4'd10; // result is src2, used by lui
	localparam logic [3:0] alu_srl    = 4'd11;
	localparam logic [3:0] alu_sll    = 4'd12;
	localparam logic [3:0] alu_sra    = 4'd13;

	// major opcodes handled by the slice
	localparam logic [6:0] opc_op     = 7'b0110011; // register-register
	localparam logic [6:0] opc_op_imm = 7'b0010011; // register-immediate
	localparam logic [6:0] opc_lui    = 7'b0110111; // load upper immediate

	// r-type field layout
	typedef struct packed {
		logic [6:0] funct7; // bit 5 selects sub / sra
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	// i-type field layout
	typedef struct packed {
		logic [11:0] imm12; // sign extended by the decoder
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	// u-type field layout
	typedef struct packed {
		logic [19:0] imm20; // upper twenty bits of the result
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_view_t;

	// one instruction word, three ways of reading it
	// rd and opcode sit at the same bits in every view
	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
		u_view_t u_view;
	} instr_u;

endpackage

/* src/rv_alu.sv */
// combinational alu of the execute slice
// takes a four bit operation code and two operands, returns result and zero flag
// sub, slt and sltu share one subtractor, shifts use the low five bits of src2
`timescale 1ns/1ns

module rv_alu (
	input  logic [3:0]                   alu_op,
	input  logic [rv_exec_pkg::xlen-1:0] src1,
	input  logic [rv_exec_pkg::xlen-1:0] src2,
	output logic [rv_exec_pkg::xlen-1:0] result,
	output logic                         zero
);

	logic [rv_exec_pkg::xlen:0]                 diff_full; // carry out in the top bit
	logic [rv_exec_pkg::xlen-1:0]               diff;
	logic                                       ovf;       // signed overflow of src1 - src2
	logic                                       lt_s;
	logic                                       lt_u;
	logic [$clog2(rv_exec_pkg::xlen)-1:0]       shamt;

	// src1 + ~src2 + 1, one extra bit keeps the carry
	assign diff_full = {1'b0, src1} + {1'b0, ~src2} + {{rv_exec_pkg::xlen{1'b0}}, 1'b1};
	assign diff      = diff_full[rv_exec_pkg::xlen-1:0];

	// overflow only when operand signs differ and the difference
	// took the sign of src2
	assign ovf = (src1[rv_exec_pkg::xlen-1] ^ src2[rv_exec_pkg::xlen-1])
		& (diff[rv_exec_pkg::xlen-1] ^ src1[rv_exec_pkg::xlen-1]);

	assign lt_s  = diff[rv_exec_pkg::xlen-1] ^ ovf; // corrected sign
	assign lt_u  = ~diff_full[rv_exec_pkg::xlen];   // no carry means a borrow
	assign shamt = src2[$clog2(rv_exec_pkg::xlen)-1:0]; // upper bits of src2 ignored

	always_comb begin
		case (alu_op)
			rv_exec_pkg::alu_add: begin
				result = src1 + src2;
			end
			rv_exec_pkg::alu_sub: begin
				result = diff;
			end
			rv_exec_pkg::alu_slt: begin
				result = {{(rv_exec_pkg::xlen-1){1'b0}}, lt_s};
			end
			rv_exec_pkg::alu_sltu: begin
				result = {{(rv_exec_pkg::xlen-1){1'b0}}, lt_u};
			end
			rv_exec_pkg::alu_xor: begin
				result = src1 ^ src2;
			end
			rv_exec_pkg::alu_or: begin
				result = src1 | src2;
			end
			rv_exec_pkg::alu_and: begin
				result = src1 & src2;
			end
			rv_exec_pkg::alu_pass_b: begin
				result = src2; // lui path
			end
			rv_exec_pkg::alu_srl: begin
				result = src1 >> shamt;
			end
			rv_exec_pkg::alu_sll: begin
				result = src1 << shamt;
			end
			rv_exec_pkg::alu_sra: begin
				result = $signed(src1) >>> shamt; // sign bit fills from the left
			end
			default: begin
				result = '0; // codes 2, 6, 7 and 14, 15
			end
		endcase
	end

	assign zero = (result == '0);

	// an unknown code would quietly fall into the default arm
	always_comb begin
		assert (!$isunknown(alu_op))
			else $error("alu_op is unknown");
	end

endmodule

/* src/rv_decoder.sv */
// instruction decoder for the op, op-imm and lui groups
// splits the word into register indices, immediate and alu operation code
// raises we for a legal strobed instruction and illegal for any other opcode
`timescale 1ns/1ns

module rv_decoder (
	input  rv_exec_pkg::instr_u                inst,
	input  logic                               inst_valid,
	output logic [rv_exec_pkg::reg_addr_w-1:0] rs1,
	output logic [rv_exec_pkg::reg_addr_w-1:0] rs2,
	output logic [rv_exec_pkg::reg_addr_w-1:0] rd,
	output logic [rv_exec_pkg::xlen-1:0]       imm,
	output logic                               use_imm,
	output logic [3:0]                         alu_op,
	output logic                               we,
	output logic                               illegal
);

	logic [6:0] opcode;
	logic       legal; // opcode is one of the three groups
	logic       srai;  // op-imm right shift with the arithmetic bit set

	// funct3 to operation, alt picks sub over add and sra over srl
	function automatic logic [3:0] f3_to_op(input logic [2:0] funct3, input logic alt);
		logic [3:0] op;
		case (funct3)
			3'b000:  op = alt ? rv_exec_pkg::alu_sub : rv_exec_pkg::alu_add;
			3'b001:  op = rv_exec_pkg::alu_sll;
			3'b010:  op = rv_exec_pkg::alu_slt;
			3'b011:  op = rv_exec_pkg::alu_sltu;
			3'b100:  op = rv_exec_pkg::alu_xor;
			3'b101:  op = alt ? rv_exec_pkg::alu_sra : rv_exec_pkg::alu_srl;
			3'b110:  op = rv_exec_pkg::alu_or;
			default: op = rv_exec_pkg::alu_and; // 3'b111
		endcase
		return op;
	endfunction

	assign opcode = inst.r_view.opcode; // same bits in every view
	assign rd     = inst.u_view.rd;

	// addi has no subtract form, only the shift keeps the funct7 bit
	assign srai = (inst.i_view.funct3 == 3'b101) && inst.i_view.imm12[10];

	always_comb begin
		rs1     = '0;
		rs2     = '0;
		imm     = '0;
		use_imm = 1'b0;
		alu_op  = rv_exec_pkg::alu_add; // harmless default, we stays low
		legal   = 1'b0;
		case (opcode)
			rv_exec_pkg::opc_op: begin
				rs1    = inst.r_view.rs1;
				rs2    = inst.r_view.rs2;
				alu_op = f3_to_op(inst.r_view.funct3, inst.r_view.funct7[5]);
				legal  = 1'b1;
			end
			rv_exec_pkg::opc_op_imm: begin
				rs1     = inst.i_view.rs1;
				imm     = {{(rv_exec_pkg::xlen-12){inst.i_view.imm12[11]}},
					inst.i_view.imm12};
				use_imm = 1'b1;
				alu_op  = f3_to_op(inst.i_view.funct3, srai);
				legal   = 1'b1;
			end
			rv_exec_pkg::opc_lui: begin
				// no register read, operand comes straight from the word
				imm     = {inst.u_view.imm20, 12'b0};
				use_imm = 1'b1;
				alu_op  = rv_exec_pkg::alu_pass_b;
				legal   = 1'b1;
			end
			default: begin
				legal = 1'b0; // loads, stores, branches and the rest
			end
		endcase
	end

	assign we      = inst_valid & legal;
	assign illegal = inst_valid & ~legal;

	// a strobed word with an unknown opcode leaves both flags unknown
	always_comb begin
		assert (!$isunknown({we, illegal}))
			else $error("decoder write enable or illegal flag is unknown");
	end

endmodule

/* src/rv_regfile.sv */
// 32 x 32 bit integer register file
// two combinational read ports and one write port on the rising edge
// x0 has no storage and always reads zero
`timescale 1ns/1ns

module rv_regfile (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic [rv_exec_pkg::reg_addr_w-1:0] rs1,
	input  logic [rv_exec_pkg::reg_addr_w-1:0] rs2,
	input  logic                               we,
	input  logic [rv_exec_pkg::reg_addr_w-1:0] rd,
	input  logic [rv_exec_pkg::xlen-1:0]       wdata,
	output logic [rv_exec_pkg::xlen-1:0]       rs1_data,
	output logic [rv_exec_pkg::xlen-1:0]       rs2_data
);

	logic [rv_exec_pkg::xlen-1:0] regs [1:31]; // x1 to x31 only

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0; // every register starts at zero
			end
		end else if (we && (rd != '0)) begin
			regs[rd] <= wdata; // writes to x0 are dropped
		end
	end

	// the value written at this edge is seen by the next instruction
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

	// every entry leaves reset cleared and only known results are written
	assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown(rs1_data) && !$isunknown(rs2_data))
		else $error("register read returned unknown data");

endmodule

/* src/rv_exec_top.sv */
// top level of the integer execute slice
// decodes a strobed instruction, reads operands, runs the alu and writes back
// write-back ports and the illegal pulse appear one cycle after inst_valid
`timescale 1ns/1ns

module rv_exec_top (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic                               inst_valid, // one cycle strobe
	input  logic [rv_exec_pkg::xlen-1:0]       inst,
	output logic                               wb_valid,
	output logic [rv_exec_pkg::reg_addr_w-1:0] wb_rd,
	output logic [rv_exec_pkg::xlen-1:0]       wb_data,
	output logic                               wb_zero,
	output logic                               illegal
);

	rv_exec_pkg::instr_u                inst_w;
	logic [rv_exec_pkg::reg_addr_w-1:0] rs1;
	logic [rv_exec_pkg::reg_addr_w-1:0] rs2;
	logic [rv_exec_pkg::reg_addr_w-1:0] rd;
	logic [rv_exec_pkg::xlen-1:0]       imm;
	logic [rv_exec_pkg::xlen-1:0]       rs1_data;
	logic [rv_exec_pkg::xlen-1:0]       rs2_data;
	logic [rv_exec_pkg::xlen-1:0]       src2;     // second alu operand
	logic [rv_exec_pkg::xlen-1:0]       result;
	logic [3:0]                         alu_op;
	logic                               use_imm;
	logic                               we;
	logic                               dec_illegal;
	logic                               zero;

	assign inst_w = inst;

	rv_decoder rv_decoder_inst (
		.inst       (inst_w),
		.inst_valid (inst_valid),
		.rs1        (rs1),
		.rs2        (rs2),
		.rd         (rd),
		.imm        (imm),
		.use_imm    (use_imm),
		.alu_op     (alu_op),
		.we         (we),
		.illegal    (dec_illegal)
	);

	rv_regfile rv_regfile_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1      (rs1),
		.rs2      (rs2),
		.we       (we),
		.rd       (rd),
		.wdata    (result), // alu result goes straight back
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	assign src2 = use_imm ? imm : rs2_data; // op-imm and lui take the immediate

	rv_alu rv_alu_inst (
		.alu_op (alu_op),
		.src1   (rs1_data),
		.src2   (src2),
		.result (result),
		.zero   (zero)
	);

	// write-back stage, lands on the same edge as the register write
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_valid <= 1'b0;
			wb_rd    <= '0;
			wb_data  <= '0;
			wb_zero  <= 1'b0;
			illegal  <= 1'b0;
		end else begin
			wb_valid <= we;          // low again after one cycle
			illegal  <= dec_illegal;
			if (we) begin
				wb_rd   <= rd;       // x0 is still reported here
				wb_data <= result;
				wb_zero <= zero;
			end
		end
	end

endmodule

/* verif/rv_exec_model.svh */
// reference model for the execute slice testbench, included inside the testbench module
// keeps a shadow copy of the register file and predicts each write-back from the rv32i rules
// model_issue predicts one strobed instruction, model_idle a cycle with no strobe
`ifndef rv_exec_model_svh
`define rv_exec_model_svh

logic [31:0] shadow [0:31]; // x0 entry is never written
logic        pred_valid;    // prediction for the instruction presented this cycle
logic        pred_illegal;
logic [4:0]  pred_rd;
logic [31:0] pred_data;
logic        pred_zero;

// result of one op, op-imm or lui instruction for operand values a and b
function automatic logic [31:0] expected_result(input logic [31:0] word, input logic [31:0] a,
	input logic [31:0] b);
	logic [31:0] r;
	logic        alt;    // instruction bit 30
	logic [4:0]  amount; // shift distance
	alt    = word[30];
	amount = b[4:0];
	r      = '0;
	if (word[6:0] == rv_exec_pkg::opc_lui) begin
		r = b; // immediate already holds the upper bits
	end else begin
		case (word[14:12])
			3'b000: r = (alt && word[6:0] == rv_exec_pkg::opc_op) ? a - b : a + b; // no subi
			3'b001: r = a << amount;
			3'b010: r = {31'b0, ($signed(a) < $signed(b))};
			3'b011: r = {31'b0, (a < b)};
			3'b100: r = a ^ b;
			3'b101: begin
				if (alt)
					r = $signed(a) >>> amount; // sign fills from the left
				else
					r = a >> amount;
			end
			3'b110: r = a | b;
			default: r = a & b;
		endcase
	end
	return r;
endfunction

task automatic model_reset();
	for (int i = 0; i < 32; i++) begin
		shadow[i] = '0; // matches the cleared registers
	end
	pred_valid   = 1'b0;
	pred_illegal = 1'b0;
	pred_rd      = '0;
	pred_data    = '0;
	pred_zero    = 1'b0;
endtask

task automatic model_issue(input logic [31:0] word);
	logic [6:0]  opcode;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] r;
	opcode = word[6:0];
	a      = shadow[word[19:15]];
	if (opcode == rv_exec_pkg::opc_op)
		b = shadow[word[24:20]];
	else if (opcode == rv_exec_pkg::opc_lui)
		b = {word[31:12], 12'b0};
	else
		b = {{20{word[31]}}, word[31:20]}; // i-type immediate, sign extended
	if (opcode == rv_exec_pkg::opc_op || opcode == rv_exec_pkg::opc_op_imm
		|| opcode == rv_exec_pkg::opc_lui) begin
		r            = expected_result(word, a, b);
		pred_valid   = 1'b1;
		pred_illegal = 1'b0;
		pred_rd      = word[11:7];
		pred_data    = r;
		pred_zero    = (r == '0);
		if (word[11:7] != 5'd0) begin
			shadow[word[11:7]] = r; // next instruction sees it
		end
	end else begin
		pred_valid   = 1'b0; // shadow left as it is
		pred_illegal = 1'b1;
	end
endtask

task automatic model_idle();
	pred_valid   = 1'b0;
	pred_illegal = 1'b0;
endtask

`endif

/* verif/rv_exec_tb.sv */
// testbench for the rv32i execute slice
// runs a directed list then a seeded random stream, predicts every write-back
// with the included model and checks the dut outputs with concurrent assertions
`timescale 1ns/1ns

module rv_exec_tb;

	localparam int reset_cycles   = 5;
	localparam int n_directed     = 12;
	localparam int n_random       = 300;
	localparam int timeout_cycles = reset_cycles + n_directed + n_random + 20;

	logic        clk;
	logic        arst_n;
	logic        inst_valid;
	logic [31:0] inst;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        wb_zero;
	logic        illegal;

	logic        exp_valid; // prediction delayed to line up with the dut outputs
	logic        exp_illegal;
	logic [4:0]  exp_rd;
	logic [31:0] exp_data;
	logic        exp_zero;
	logic        exp_started; // a write-back has happened since reset
	logic [31:0] directed [n_directed];
	integer      seed = 87;
	int          cycle_count = 0;

	`include "rv_exec_model.svh"

	rv_exec_top rv_exec_top_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data),
		.wb_zero    (wb_zero),
		.illegal    (illegal)
	);

	always #20 clk = ~clk; // 40 ns period

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_valid   <= 1'b0;
			exp_illegal <= 1'b0;
			exp_rd      <= '0;
			exp_data    <= '0;
			exp_zero    <= 1'b0;
			exp_started <= 1'b0;
		end else begin
			exp_valid   <= pred_valid;
			exp_illegal <= pred_illegal;
			exp_rd      <= pred_rd;
			exp_data    <= pred_data;
			exp_zero    <= pred_zero;
			exp_started <= exp_started | pred_valid;
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		stop_with_failure($sformatf("FAIL %s expected %h actual %h", name, expected, actual));
	endtask

	// exactly one cycle from strobe to write-back or illegal pulse
	assert property (@(posedge clk) disable iff (!arst_n) wb_valid == exp_valid)
		else report_mismatch("wb_valid", 32'($sampled(exp_valid)), 32'($sampled(wb_valid)));
	assert property (@(posedge clk) disable iff (!arst_n) illegal == exp_illegal)
		else report_mismatch("illegal", 32'($sampled(exp_illegal)), 32'($sampled(illegal)));
	assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> wb_rd == exp_rd)
		else report_mismatch("wb_rd", 32'($sampled(exp_rd)), 32'($sampled(wb_rd)));
	assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> wb_data == exp_data)
		else report_mismatch("wb_data", $sampled(exp_data), $sampled(wb_data));
	assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> wb_zero == exp_zero)
		else report_mismatch("wb_zero", 32'($sampled(exp_zero)), 32'($sampled(wb_zero)));
	// flag must agree with the data it travels with
	assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> wb_zero == (wb_data == '0))
		else report_mismatch("wb_zero", 32'($sampled(wb_data) == '0), 32'($sampled(wb_zero)));
	// reset values hold until the first write-back
	assert property (@(posedge clk) disable iff (!arst_n) !exp_started |-> wb_data == '0)
		else report_mismatch("wb_data", 32'h0, $sampled(wb_data));
	assert property (@(posedge clk) disable iff (!arst_n) !exp_started |-> wb_rd == '0)
		else report_mismatch("wb_rd", 32'h0, 32'($sampled(wb_rd)));

	function automatic logic [31:0] op_word(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, rv_exec_pkg::opc_op};
	endfunction

	function automatic logic [31:0] imm_word(input logic [11:0] imm12, input logic [4:0] rs1,
		input logic [2:0] funct3, input logic [4:0] rd);
		return {imm12, rs1, funct3, rd, rv_exec_pkg::opc_op_imm};
	endfunction

	function automatic logic [31:0] lui_word(input logic [19:0] imm20, input logic [4:0] rd);
		return {imm20, rd, rv_exec_pkg::opc_lui};
	endfunction

	task automatic drive_inst(input logic [31:0] word);
		@(posedge clk);
		#2;
		inst_valid = 1'b1;
		inst       = word;
		model_issue(word);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		#2;
		inst_valid = 1'b0;
		inst       = '0;
		model_idle();
	endtask

	task automatic load_directed();
		directed[0]  = op_word(7'h00, 5'd0, 5'd7, 3'b000, 5'd5);   // add x5,x7,x0 after reset
		directed[1]  = lui_word(20'h80000, 5'd1);                  // x1 = most negative
		directed[2]  = imm_word(12'hfff, 5'd1, 3'b000, 5'd2);      // x2 = x1 - 1, back to back
		directed[3]  = op_word(7'h00, 5'd2, 5'd1, 3'b010, 5'd3);   // slt, difference overflows
		directed[4]  = op_word(7'h00, 5'd2, 5'd1, 3'b011, 5'd4);   // sltu on the same pair
		directed[5]  = imm_word(12'hfe4, 5'd0, 3'b000, 5'd7);      // x7 = -28, low five bits 4
		directed[6]  = op_word(7'h20, 5'd7, 5'd1, 3'b101, 5'd8);   // sra by x7
		directed[7]  = imm_word(12'h41f, 5'd1, 3'b101, 5'd9);      // srai 31
		directed[8]  = op_word(7'h00, 5'd2, 5'd2, 3'b000, 5'd0);   // write aimed at x0
		directed[9]  = op_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd10);  // x0 still reads zero
		directed[10] = {12'h004, 5'd1, 3'b010, 5'd2, 7'b0000011}; // load, not supported
		directed[11] = op_word(7'h00, 5'd0, 5'd2, 3'b000, 5'd11);  // x2 survived the load
	endtask

	task automatic pick_random(output logic [31:0] word);
		logic [31:0] sel;
		logic [31:0] bits;
		logic [2:0]  f3;
		logic [11:0] imm;
		logic [6:0]  opcode;
		sel  = $random(seed);
		bits = $random(seed);
		f3   = bits[14:12];
		case (sel[2:0])
			3'd0, 3'd1, 3'd2: begin
				// only add and srl have a second form
				word = op_word({1'b0, sel[8] & (f3 == 3'b000 || f3 == 3'b101), 5'b0},
					bits[24:20], bits[19:15], f3, bits[11:7]);
			end
			3'd3, 3'd4, 3'd5: begin
				imm = bits[31:20];
				if (f3 == 3'b001)
					imm[11:5] = 7'b0;                   // slli
				else if (f3 == 3'b101)
					imm[11:5] = {1'b0, sel[8], 5'b0};   // srli or srai
				word = imm_word(imm, bits[19:15], f3, bits[11:7]);
			end
			default: begin
				if (sel[2:0] == 3'd7 && sel[4]) begin
					opcode = bits[6:0];
					if (opcode == rv_exec_pkg::opc_op || opcode == rv_exec_pkg::opc_op_imm
						|| opcode == rv_exec_pkg::opc_lui)
						opcode = 7'b1100011; // branch, unsupported
					word = {bits[31:7], opcode};
				end else begin
					word = lui_word(bits[31:12], bits[11:7]);
				end
			end
		endcase
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
			stop_with_failure($sformatf("run timed out after %0d cycles", cycle_count));
	end

	initial begin
		logic [31:0] word;
		clk        = 1'b0;
		arst_n     = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		model_reset();
		load_directed();
		repeat (reset_cycles) @(posedge clk);
		#2;
		arst_n = 1'b1;
		drive_idle(); // outputs stay quiet before the first strobe
		drive_idle();
		for (int i = 0; i < n_directed; i++) begin
			drive_inst(directed[i]);
		end
		repeat (n_random) begin
			pick_random(word);
			drive_inst(word);
		end
		drive_idle();
		repeat (3) @(posedge clk); // last write-back gets checked
		#2;
		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+verif
src/rv_exec_pkg.sv
src/rv_alu.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_exec_top.sv
verif/rv_exec_tb.sv

/* run.sh */
#!/bin/sh
# build the execute slice testbench with Verilator and run it
# passes only when the simulation output holds the pass message

verilator --binary --timing --assert -f verilog.f --top-module rv_exec_tb -o rv_exec_sim \
	&& ./obj_dir/rv_exec_sim 2>&1 | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
